//--- ca_rx_align.f
ca_rx_align_pkg.sv
ca_strobe_detect.sv
ca_lane_fifo.sv
ca_interval_check.sv
ca_strobe_cfg_check.sv
ca_align_ctrl.sv
ca_rx_align.sv
tb_ca_rx_align.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the aligner testbench with Verilator, then scan the log
verilator --binary --timing -j 0 --top-module tb_ca_rx_align -f ca_rx_align.f \
  -o sim_tb > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "Simulation FAILED"; exit 1; } || \
  { echo "Simulation PASSED"; exit 0; }

//--- ca_rx_align_input.txt
01 0000000001 16 0 2 0 1 4 0 1 0 0 0
02 0000000100 16 2 3 0 3 6 0 1 0 0 0
01 0000000001 16 0 0 0 1 20 0 0 1 0 0
01 0000080000 16 0 1 0 1 3 32 1 1 0 0
01 0000000001 16 0 1 1 1 4 32 1 0 0 0
01 0000000003 16 0 0 0 1 1 0 0 0 0 1
04 0000000001 16 0 0 0 1 1 0 0 0 1 0
00 0000000001 16 0 0 0 1 1 0 0 0 0 1
01 0000000010 8 1 0 0 2 2 0 1 0 0 0

//--- tb_ca_rx_align.sv
// Testbench for the receive channel aligner with file driven cases and checks
`timescale 1ns/10ps

module tb_ca_rx_align;

  localparam int CASE_CYCLES = 80;
  localparam int RST_CYCLES  = 8;
  localparam int MAX_CASES   = 32;

  logic                         com_clk;
  logic                         rst_com_n;
  ca_rx_align_pkg::chan_data_u  rx_din [ca_rx_align_pkg::NUM_CHANNELS];
  logic                         rx_online;
  ca_rx_align_pkg::align_cfg_t  align_cfg;
  ca_rx_align_pkg::stb_cfg_t    stb_cfg;
  ca_rx_align_pkg::chan_data_u  rx_dout [ca_rx_align_pkg::NUM_CHANNELS];
  logic                         rx_dout_valid;
  logic                         align_done;
  logic                         align_err;
  logic                         rx_stb_pos_err;
  logic                         rx_stb_pos_coding_err;

  // Case table with one entry per line of the input file
  logic [7:0]  c_wd_sel [MAX_CASES];
  logic [39:0] c_bit_sel [MAX_CASES];
  int          c_intv [MAX_CASES];
  int          c_count_x [MAX_CASES];
  int          c_rden [MAX_CASES];
  int          c_fly [MAX_CASES];
  int          c_skew0 [MAX_CASES];
  int          c_skew1 [MAX_CASES];
  int          c_drop [MAX_CASES];
  int          c_exp [MAX_CASES][4];   // done, err, pos, coding

  int          num_cases;
  int          seed;
  int          cycle_cnt;
  int          cycle_limit;

  ca_rx_align u_ca_rx_align (
    .com_clk               (com_clk),
    .rst_com_n             (rst_com_n),
    .rx_din                (rx_din),
    .rx_online             (rx_online),
    .align_cfg             (align_cfg),
    .stb_cfg               (stb_cfg),
    .rx_dout               (rx_dout),
    .rx_dout_valid         (rx_dout_valid),
    .align_done            (align_done),
    .align_err             (align_err),
    .rx_stb_pos_err        (rx_stb_pos_err),
    .rx_stb_pos_coding_err (rx_stb_pos_coding_err)
  );

  initial com_clk = 1'b0;
  always #20 com_clk = ~com_clk;

  // Run limit from the number of cases
  always @(posedge com_clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit)
    begin
      $display("Timeout: the run went past %0d clock cycles", cycle_limit);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "value mismatch");
    end
  endtask

  // Strobe bit position as word index times 40 plus bit index
  function automatic int strobe_loc(input logic [7:0] wd, input logic [39:0] bs);
    int w;
    int b;
    w = 0;
    b = 0;
    for (int i = 0; i < 8; i++)
      if (wd[i])
        w = i;
    for (int i = 0; i < 40; i++)
      if (bs[i])
        b = i;
    return w * 40 + b;
  endfunction

  // Strobe expected on this word unless it is the dropped one
  function automatic logic strobe_due(input int c, input int seq);
    return (seq % c_intv[c] == 0) && !(c_drop[c] != 0 && seq == c_drop[c]);
  endfunction

  // Sequence number in bits 79:64 and a strobe every intv words
  task automatic drive_lanes(input int c, input int t);
    int          seq;
    int          loc;
    logic [95:0] w;
    loc = strobe_loc(c_wd_sel[c], c_bit_sel[c]);
    for (int i = 0; i < ca_rx_align_pkg::NUM_CHANNELS; i++)
    begin
      seq = t - ((i == 0) ? c_skew0[c] : c_skew1[c]);
      w = {$random(seed), $random(seed), $random(seed)};
      if (loc < 80)
        w[loc] = 1'b0;
      if (seq >= 0)
      begin
        w[79:64] = seq[15:0];
        if (strobe_due(c, seq))
          w[loc] = 1'b1;
      end
      rx_din[i].payload = w[79:0];
    end
  endtask

  task automatic run_case(input int c);
    logic        done_seen;
    logic        done_fell;
    logic        have_prev;
    logic [15:0] prev;
    logic [15:0] seq0;
    int          beats;
    int          loc;
    rst_com_n = 1'b0;
    rx_online = 1'b0;
    stb_cfg   = '{wd_sel: c_wd_sel[c], bit_sel: c_bit_sel[c], intv: 8'(c_intv[c])};
    align_cfg = '{align_fly: c_fly[c][0], rden_dly: 3'(c_rden[c]), count_x: 8'(c_count_x[c])};
    loc       = strobe_loc(c_wd_sel[c], c_bit_sel[c]);
    drive_lanes(c, -100);
    repeat (RST_CYCLES) @(negedge com_clk);
    rst_com_n = 1'b1;
    check("rx_dout_valid", 64'(rx_dout_valid), 64'd0);
    check("align_done", 64'(align_done), 64'd0);
    check("align_err", 64'(align_err), 64'd0);
    check("rx_stb_pos_err", 64'(rx_stb_pos_err), 64'(c_exp[c][2]));
    check("rx_stb_pos_coding_err", 64'(rx_stb_pos_coding_err), 64'(c_exp[c][3]));
    if (c_exp[c][2] == 0 && c_exp[c][3] == 0)
    begin
      done_seen = 1'b0;
      done_fell = 1'b0;
      have_prev = 1'b0;
      prev      = 16'd0;
      seq0      = 16'd0;
      beats     = 0;
      for (int t = 0; t < CASE_CYCLES; t++)
      begin
        @(negedge com_clk);
        if (align_done)
          done_seen = 1'b1;
        else if (done_seen)
          done_fell = 1'b1;
        if (rx_dout_valid)
        begin
          seq0 = rx_dout[0].payload[79:64];
          check("rx_dout[1] seq", 64'(rx_dout[1].payload[79:64]), 64'(seq0));
          if (have_prev)
            check("rx_dout[0] seq step", 64'(seq0), 64'(prev + 16'd1));
          else
            check("rx_dout[0] first seq", 64'(seq0 % 16'(c_intv[c])), 64'd0);  // Strobe word
          for (int i = 0; i < ca_rx_align_pkg::NUM_CHANNELS; i++)
            check($sformatf("rx_dout[%0d] strobe bit", i), 64'(rx_dout[i].payload[loc]),
                  64'(strobe_due(c, int'(seq0))));
          prev      = seq0;
          have_prev = 1'b1;
          beats     = beats + 1;
        end
        else
          have_prev = 1'b0;   // New run of beats
        rx_online = 1'b1;
        drive_lanes(c, t);
      end
      check("align_done", 64'(align_done), 64'(c_exp[c][0]));
      check("align_err", 64'(align_err), 64'(c_exp[c][1]));
      if (c_exp[c][0] == 0)
        check("align_done seen", 64'(done_seen), 64'd0);
      else
        check("rx_dout_valid seen", 64'(beats > 0), 64'd1);
      check("align_done fell", 64'(done_fell), 64'(c_fly[c] != 0 && c_drop[c] != 0));
    end
  endtask

  initial
  begin
    int fd;
    int r;
    seed        = 32'hffa628b3;
    cycle_cnt   = 0;
    cycle_limit = 0;
    num_cases   = 0;
    rst_com_n   = 1'b0;
    rx_online   = 1'b0;
    align_cfg   = '0;
    stb_cfg     = '0;
    for (int i = 0; i < ca_rx_align_pkg::NUM_CHANNELS; i++)
      rx_din[i] = '0;

    ////////////////////////////////
    // Load the case table
    ////////////////////////////////
    fd = $fopen("ca_rx_align_input.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the input file ca_rx_align_input.txt");
      $display("Finished with errors");
      $fatal(1, "no input file");
    end
    while (num_cases < MAX_CASES)
    begin
      r = $fscanf(fd, "%h %h %d %d %d %d %d %d %d %d %d %d %d",
                  c_wd_sel[num_cases], c_bit_sel[num_cases], c_intv[num_cases],
                  c_count_x[num_cases], c_rden[num_cases], c_fly[num_cases],
                  c_skew0[num_cases], c_skew1[num_cases], c_drop[num_cases],
                  c_exp[num_cases][0], c_exp[num_cases][1], c_exp[num_cases][2],
                  c_exp[num_cases][3]);
      if (r != 13)
        break;
      num_cases = num_cases + 1;
    end
    $fclose(fd);
    if (num_cases == 0)
    begin
      $display("The input file holds no test cases");
      $display("Finished with errors");
      $fatal(1, "empty input");
    end
    cycle_limit = num_cases * (RST_CYCLES + CASE_CYCLES + 2) + 50;   // With margin

    for (int c = 0; c < num_cases; c++)
      run_case(c);

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- ca_rx_align.sv
// Top level of the receive channel aligner with lane stages and controller
`timescale 1ns/10ps

module ca_rx_align (
  input  logic                         com_clk,
  input  logic                         rst_com_n,
  input  ca_rx_align_pkg::chan_data_u  rx_din [ca_rx_align_pkg::NUM_CHANNELS],
  input  logic                         rx_online,
  input  ca_rx_align_pkg::align_cfg_t  align_cfg,
  input  ca_rx_align_pkg::stb_cfg_t    stb_cfg,
  output ca_rx_align_pkg::chan_data_u  rx_dout [ca_rx_align_pkg::NUM_CHANNELS],
  output logic                         rx_dout_valid,
  output logic                         align_done,
  output logic                         align_err,
  output logic                         rx_stb_pos_err,
  output logic                         rx_stb_pos_coding_err
);

  ca_rx_align_pkg::lane_wr_t                lane_wr [ca_rx_align_pkg::NUM_CHANNELS];
  logic [ca_rx_align_pkg::NUM_CHANNELS-1:0] lane_started;
  logic [ca_rx_align_pkg::NUM_CHANNELS-1:0] overflow;
  logic [ca_rx_align_pkg::NUM_CHANNELS-1:0] intv_err;
  logic                                     detect_en;
  logic                                     soft_reset;
  logic                                     pop;

  //////////////////////////////
  // Lane stages
  //////////////////////////////
  for (genvar i = 0; i < ca_rx_align_pkg::NUM_CHANNELS; i++)
  begin : g_lane
    ca_strobe_detect u_detect (
      .com_clk      (com_clk),
      .rst_com_n    (rst_com_n),
      .rx_din       (rx_din[i]),
      .rx_online    (rx_online),
      .count_x      (align_cfg.count_x),
      .stb_cfg      (stb_cfg),
      .detect_en    (detect_en),
      .soft_reset   (soft_reset),
      .lane_wr      (lane_wr[i]),
      .lane_started (lane_started[i])
    );

    ca_lane_fifo u_fifo (
      .com_clk    (com_clk),
      .rst_com_n  (rst_com_n),
      .lane_wr    (lane_wr[i]),
      .pop        (pop),
      .soft_reset (soft_reset),
      .head       (rx_dout[i]),   // Straight to output
      .overflow   (overflow[i])
    );

    ca_interval_check u_intv (
      .com_clk    (com_clk),
      .rst_com_n  (rst_com_n),
      .lane_wr    (lane_wr[i]),
      .intv       (stb_cfg.intv),
      .soft_reset (soft_reset),
      .intv_err   (intv_err[i])
    );
  end

  // Shared control
  ca_strobe_cfg_check u_cfg_check (
    .stb_cfg               (stb_cfg),
    .rx_stb_pos_err        (rx_stb_pos_err),
    .rx_stb_pos_coding_err (rx_stb_pos_coding_err)
  );

  ca_align_ctrl u_ctrl (
    .com_clk      (com_clk),
    .rst_com_n    (rst_com_n),
    .rx_online    (rx_online),
    .align_cfg    (align_cfg),
    .lane_started (lane_started),
    .overflow     (overflow),
    .intv_err     (intv_err),
    .detect_en    (detect_en),
    .soft_reset   (soft_reset),
    .pop          (pop),
    .align_done   (align_done),
    .align_err    (align_err)
  );

  assign rx_dout_valid = pop;   // Heads are read in this cycle

endmodule

//--- ca_align_ctrl.sv
// Alignment FSM, read-start delay, common FIFO pop and done/err flags
`timescale 1ns/10ps

module ca_align_ctrl (
  input  logic                                    com_clk,
  input  logic                                    rst_com_n,
  input  logic                                    rx_online,
  input  ca_rx_align_pkg::align_cfg_t             align_cfg,
  input  logic [ca_rx_align_pkg::NUM_CHANNELS-1:0] lane_started,
  input  logic [ca_rx_align_pkg::NUM_CHANNELS-1:0] overflow,
  input  logic [ca_rx_align_pkg::NUM_CHANNELS-1:0] intv_err,
  output logic                                    detect_en,
  output logic                                    soft_reset,
  output logic                                    pop,
  output logic                                    align_done,
  output logic                                    align_err
);

  logic [2:0]  state;
  logic [2:0]  d_state;
  logic        d_align_done;
  logic        d_align_err;
  logic [2:0]  rd_dly;
  logic        online_q;
  logic        fly_q;
  logic        fly_rise;
  logic        all_started;

  assign all_started = &lane_started;
  assign fly_rise    = align_cfg.align_fly & ~fly_q;

  //////////////////////////////
  // Read delay and pop
  //////////////////////////////
  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      online_q   <= 1'b0;
      fly_q      <= 1'b0;
      rd_dly     <= 3'd0;
      state      <= ca_rx_align_pkg::ST_IDLE;
      align_done <= 1'b0;
      align_err  <= 1'b0;
    end
    else
    begin
      online_q <= rx_online;
      fly_q    <= align_cfg.align_fly;
      if (rx_online && !online_q)
        rd_dly <= align_cfg.rden_dly;
      else if (all_started && (rd_dly != 3'd0))
        rd_dly <= rd_dly - 3'd1;
      state      <= d_state;
      align_done <= d_align_done;
      align_err  <= d_align_err;
    end
  end

  assign pop        = all_started & (rd_dly == 3'd0);
  assign soft_reset = (state == ca_rx_align_pkg::ST_SOFT_RESET);
  assign detect_en  = (state == ca_rx_align_pkg::ST_ONLINE) ||
                      (state == ca_rx_align_pkg::ST_ALIGNED) ||
                      (state == ca_rx_align_pkg::ST_DONE);

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb
  begin
    d_state      = state;
    d_align_done = 1'b0;
    d_align_err  = 1'b0;
    case (state)
      ca_rx_align_pkg::ST_IDLE:
      begin
        if (rx_online)
          d_state = ca_rx_align_pkg::ST_ONLINE;
      end
      ca_rx_align_pkg::ST_ONLINE:
      begin
        if (|overflow)   // Skew beyond FIFO depth
          d_state = align_cfg.align_fly ? ca_rx_align_pkg::ST_SOFT_RESET
                                        : ca_rx_align_pkg::ST_ERR;
        else if (all_started)
          d_state = ca_rx_align_pkg::ST_ALIGNED;
      end
      ca_rx_align_pkg::ST_ALIGNED:
      begin
        if (rd_dly == 3'd0)
          d_state = ca_rx_align_pkg::ST_DONE;
      end
      ca_rx_align_pkg::ST_ERR:
      begin
        d_align_err = ~fly_rise;
        if (fly_rise)
          d_state = ca_rx_align_pkg::ST_SOFT_RESET;
      end
      ca_rx_align_pkg::ST_DONE:
      begin
        d_align_done = 1'b1;
        if (|intv_err)
        begin
          d_align_err = 1'b1;
          if (align_cfg.align_fly)
            d_state = ca_rx_align_pkg::ST_SOFT_RESET;
        end
      end
      ca_rx_align_pkg::ST_SOFT_RESET: d_state = ca_rx_align_pkg::ST_ONLINE;
      default:                        d_state = ca_rx_align_pkg::ST_IDLE;
    endcase
  end

endmodule

//--- ca_strobe_cfg_check.sv
// Coding and range check of the strobe position configuration
`timescale 1ns/10ps

module ca_strobe_cfg_check (
  input  ca_rx_align_pkg::stb_cfg_t  stb_cfg,
  output logic                       rx_stb_pos_err,
  output logic                       rx_stb_pos_coding_err
);

  logic [3:0]  wd_ones;
  logic [5:0]  bit_ones;
  logic [2:0]  wd_idx;
  logic [5:0]  bit_idx;
  logic [8:0]  stb_loc;

  always_comb
  begin
    wd_ones = 4'd0;
    wd_idx  = 3'd0;
    for (int i = ca_rx_align_pkg::STB_WD_SEL_BITS - 1; i >= 0; i--)
    begin
      wd_ones = wd_ones + {3'd0, stb_cfg.wd_sel[i]};
      if (stb_cfg.wd_sel[i])
        wd_idx = 3'(i);          // Lowest set bit ends up here
    end
  end

  always_comb
  begin
    bit_ones = 6'd0;
    bit_idx  = 6'd0;
    for (int i = 0; i < ca_rx_align_pkg::STB_WORD_BITS; i++)
    begin
      bit_ones = bit_ones + {5'd0, stb_cfg.bit_sel[i]};
      if (stb_cfg.bit_sel[i])
        bit_idx = 6'(i);
    end
  end

  // Word start plus bit offset
  assign stb_loc = 9'(wd_idx) * 9'(ca_rx_align_pkg::STB_WORD_BITS) + 9'(bit_idx);

  assign rx_stb_pos_coding_err = (wd_ones != 4'd1) || (bit_ones != 6'd1);
  assign rx_stb_pos_err        = (stb_loc >= 9'(ca_rx_align_pkg::BITS_PER_CHANNEL));

endmodule

//--- ca_interval_check.sv
// Per-lane strobe interval checker with sticky error
`timescale 1ns/10ps

module ca_interval_check (
  input  logic                       com_clk,
  input  logic                       rst_com_n,
  input  ca_rx_align_pkg::lane_wr_t  lane_wr,
  input  logic [7:0]                 intv,
  input  logic                       soft_reset,
  output logic                       intv_err
);

  logic [7:0]  words_left;   // Words until next strobe is due
  logic        armed;

  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      words_left <= 8'd0;
      armed      <= 1'b0;
      intv_err   <= 1'b0;
    end
    else if (soft_reset)
    begin
      words_left <= 8'd0;
      armed      <= 1'b0;
      intv_err   <= 1'b0;
    end
    else if (lane_wr.wr)
    begin
      if (lane_wr.stb)
      begin
        words_left <= intv;
        armed      <= 1'b1;
      end
      else if (armed)
      begin
        // Strobe due on this word but absent
        if (words_left <= 8'd1)
        begin
          intv_err   <= 1'b1;
          words_left <= intv;
        end
        else
          words_left <= words_left - 8'd1;
      end
    end
  end

endmodule

//--- ca_lane_fifo.sv
// Per-lane show-ahead alignment FIFO with soft reset and overflow pulse
`timescale 1ns/10ps

module ca_lane_fifo (
  input  logic                                       com_clk,
  input  logic                                       rst_com_n,
  input  ca_rx_align_pkg::lane_wr_t                  lane_wr,
  input  logic                                       pop,
  input  logic                                       soft_reset,
  output ca_rx_align_pkg::chan_data_u                head,
  output logic                                       overflow
);

  ca_rx_align_pkg::chan_data_u                       mem [ca_rx_align_pkg::FIFO_DEPTH];
  logic [ca_rx_align_pkg::FIFO_AD_WIDTH-1:0]         wr_ptr;
  logic [ca_rx_align_pkg::FIFO_AD_WIDTH-1:0]         rd_ptr;
  logic [ca_rx_align_pkg::FIFO_AD_WIDTH:0]           fill;
  logic                                              full;
  logic                                              empty;
  logic                                              do_push;
  logic                                              do_pop;

  assign full    = (fill == (ca_rx_align_pkg::FIFO_AD_WIDTH + 1)'(ca_rx_align_pkg::FIFO_DEPTH));
  assign empty   = (fill == '0);
  assign do_push = lane_wr.wr & ~full & ~soft_reset;
  assign do_pop  = pop & ~empty & ~soft_reset;

  //////////////////////////////
  // Pointers and fill level
  //////////////////////////////
  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      overflow <= 1'b0;
    end
    else if (soft_reset)
    begin
      wr_ptr   <= '0;   // Empty in one cycle
      rd_ptr   <= '0;
      fill     <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      overflow <= lane_wr.wr & full;   // Dropped write
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // Storage
  always_ff @(posedge com_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= lane_wr.data;
  end

  // Show-ahead, head valid whenever not empty
  assign head = mem[rd_ptr];

endmodule

//--- ca_strobe_detect.sv
// Per-lane strobe bit selection, holdoff timer and FIFO write stage
`timescale 1ns/10ps

module ca_strobe_detect (
  input  logic                                com_clk,
  input  logic                                rst_com_n,
  input  ca_rx_align_pkg::chan_data_u         rx_din,
  input  logic                                rx_online,
  input  logic [7:0]                          count_x,
  input  ca_rx_align_pkg::stb_cfg_t           stb_cfg,
  input  logic                                detect_en,
  input  logic                                soft_reset,
  output ca_rx_align_pkg::lane_wr_t           lane_wr,
  output logic                                lane_started
);

  logic [ca_rx_align_pkg::STB_WORD_BITS-1:0]  stb_word;
  logic                                       stb_hit;
  logic [7:0]                                 holdoff;
  logic                                       holdoff_zero;
  logic                                       online_q;
  logic                                       wr_q;
  logic                                       stb_q;
  ca_rx_align_pkg::chan_data_u                data_q;

  //////////////////////////////
  // Strobe word and bit
  //////////////////////////////
  // Lowest selected word wins, words past the lane width read zero
  always_comb
  begin
    stb_word = '0;
    for (int i = ca_rx_align_pkg::WORDS_PER_CHANNEL - 1; i >= 0; i--)
    begin
      if (stb_cfg.wd_sel[i])
        stb_word = rx_din.stb_wd[i];
    end
  end

  assign holdoff_zero = (holdoff == 8'd0);
  assign stb_hit      = detect_en & holdoff_zero & (|(stb_word & stb_cfg.bit_sel));

  // Holdoff after rx_online rises
  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      online_q <= 1'b0;
      holdoff  <= 8'd0;
    end
    else
    begin
      online_q <= rx_online;
      if (rx_online && !online_q)
        holdoff <= count_x;
      else if (!holdoff_zero)
        holdoff <= holdoff - 8'd1;
    end
  end

  //////////////////////////////
  // Write flags
  //////////////////////////////
  always_ff @(posedge com_clk or negedge rst_com_n)
  begin
    if (!rst_com_n)
    begin
      wr_q         <= 1'b0;
      stb_q        <= 1'b0;
      lane_started <= 1'b0;
    end
    else if (soft_reset || !rx_online)
    begin
      wr_q         <= 1'b0;
      stb_q        <= 1'b0;
      lane_started <= 1'b0;
    end
    else
    begin
      stb_q        <= stb_hit;
      wr_q         <= wr_q | stb_hit;          // Sticky from first strobe on
      lane_started <= lane_started | wr_q;     // First word now at FIFO head
    end
  end

  always_ff @(posedge com_clk)
  begin
    data_q <= rx_din;
  end

  assign lane_wr = '{wr: wr_q, stb: stb_q, data: data_q};

endmodule

//--- ca_rx_align_pkg.sv
// Lane and FIFO constants, FSM state codes, channel word union and config structs
package ca_rx_align_pkg;

  //////////////////////////////
  // Lane geometry
  //////////////////////////////
  localparam int NUM_CHANNELS      = 2;
  localparam int BITS_PER_CHANNEL  = 80;
  localparam int STB_WORD_BITS     = 40;
  localparam int WORDS_PER_CHANNEL = 2;   // BITS_PER_CHANNEL / STB_WORD_BITS
  localparam int STB_WD_SEL_BITS   = 8;

  // Alignment FIFO
  localparam int FIFO_AD_WIDTH     = 4;
  localparam int FIFO_DEPTH        = 16;

  //////////////////////////////
  // Alignment FSM states
  //////////////////////////////
  localparam logic [2:0] ST_IDLE       = 3'h0;
  localparam logic [2:0] ST_ONLINE     = 3'h1;
  localparam logic [2:0] ST_ALIGNED    = 3'h2;
  localparam logic [2:0] ST_ERR        = 3'h3;
  localparam logic [2:0] ST_DONE       = 3'h4;
  localparam logic [2:0] ST_SOFT_RESET = 3'h5;

  // One lane word, seen as payload or as strobe words
  typedef union packed {
    logic [BITS_PER_CHANNEL-1:0]                      payload;
    logic [WORDS_PER_CHANNEL-1:0][STB_WORD_BITS-1:0]  stb_wd;
  } chan_data_u;

  // Strobe position and interval
  typedef struct packed {
    logic [STB_WD_SEL_BITS-1:0] wd_sel;   // One-hot word
    logic [STB_WORD_BITS-1:0]   bit_sel;  // One-hot bit in word
    logic [7:0]                 intv;     // Words between strobes
  } stb_cfg_t;

  typedef struct packed {
    logic       align_fly;  // Re-align through soft reset
    logic [2:0] rden_dly;
    logic [7:0] count_x;    // Holdoff after rx_online
  } align_cfg_t;

  // Word leaving the strobe detector
  typedef struct packed {
    logic       wr;
    logic       stb;
    chan_data_u data;
  } lane_wr_t;

endpackage
